// File: hdl/rv_decode_config.svh
// Decoder widths, RV32I opcode values and select encodings, included by the package and RTL
`ifndef RV_DECODE_CONFIG_SVH
`define RV_DECODE_CONFIG_SVH

// Field and word widths
`define RV_INST_W     32           // Instruction word
`define RV_OPCODE_W   7            // inst[6:0]
`define RV_FUNCT3_W   3            // inst[14:12]
`define RV_FUNCT7_W   7            // inst[31:25]
`define RV_KEY_W      17           // Opcode, funct3, funct7
`define RV_CTRL_W     17           // Packed control word
`define RV_NR_KEY     38           // Control table entries

// Major opcodes
`define OPC_LUI       7'b0110111
`define OPC_AUIPC     7'b0010111
`define OPC_JAL       7'b1101111
`define OPC_JALR      7'b1100111
`define OPC_BRANCH    7'b1100011
`define OPC_LOAD      7'b0000011
`define OPC_STORE     7'b0100011
`define OPC_OP_IMM    7'b0010011
`define OPC_OP        7'b0110011
`define OPC_SYSTEM    7'b1110011

// Next-PC select codes
`define PC_SEL_SEQ    3'd0         // pc + 4
`define PC_SEL_JALR   3'd1         // rs1 + imm
`define PC_SEL_BRANCH 3'd2         // Taken branch target
`define PC_SEL_JAL    3'd3         // pc + J immediate

// The one SYSTEM word treated as ebreak
`define EBREAK_WORD   32'h00100073

`endif

// File: hdl/rv_decode_pkg.sv
// Shared decoder types: field vectors, lookup key, control word and branch flags
`default_nettype none

`include "rv_decode_config.svh"

package rv_decode_pkg;

    // Instruction fields
    typedef logic [`RV_INST_W-1:0]   inst_t;
    typedef logic [`RV_OPCODE_W-1:0] opcode_t;
    typedef logic [`RV_FUNCT3_W-1:0] funct3_t;
    typedef logic [`RV_FUNCT7_W-1:0] funct7_t;

    // Lookup key, {opcode, funct3, funct7}
    typedef logic [`RV_KEY_W-1:0]    inst_key_t;

    // Control fields
    typedef logic [4:0]              alu_op_t;      // ALU operation
    typedef logic [1:0]              opnd_sel_t;    // ALU operand source
    typedef logic [2:0]              pc_sel_t;      // Next-PC source
    typedef logic [1:0]              wb_sel_t;      // Write-back source
    typedef logic [2:0]              mem_access_t;  // Width and sign, as funct3

    // Control word, MSB first, same layout as the table literals
    typedef struct packed {
        alu_op_t   alu_op;   // [16:12]
        opnd_sel_t op1_sel;  // [11:10]
        opnd_sel_t op2_sel;  // [9:8]
        pc_sel_t   pc_sel;   // [7:5]
        logic      rf_we;    // [4]
        logic      mem_en;   // [3]
        logic      mem_wen;  // [2]
        wb_sel_t   wb_sel;   // [1:0]
    } ctrl_word_t;

    // Compare results from the branch comparator
    typedef struct packed {
        logic eq;   // rs1 == rs2
        logic lt;   // Signed rs1 < rs2
        logic ltu;  // Unsigned rs1 < rs2
    } br_flags_t;

endpackage

`default_nettype wire

// File: hdl/inst_key_former.sv
// Forms the 17-bit table key from an instruction, masking fields the format does not use
`default_nettype none

`include "rv_decode_config.svh"

module inst_key_former (
    input  rv_decode_pkg::inst_t     inst,  // Instruction word
    output rv_decode_pkg::inst_key_t key    // {opcode, funct3, funct7}
);
    import rv_decode_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        case (opcode)
            `OPC_OP_IMM: begin
                if (funct3 == 3'b101) begin            // SRLI/SRAI need funct7
                    key = {opcode, funct3, funct7};
                end else begin
                    key = {opcode, funct3, 7'b0};      // funct7 is immediate here
                end
            end
            `OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    key = {opcode, funct3, 7'b0};
                end else begin
                    key = {opcode, funct3, `OPC_JAL};  // Poisoned, hits no entry
                end
            end
            `OPC_AUIPC,
            `OPC_JAL,
            `OPC_LUI:    key = {opcode, 3'b0, 7'b0};     // Immediate fills both
            `OPC_STORE,
            `OPC_LOAD,
            `OPC_BRANCH: key = {opcode, funct3, 7'b0};   // Upper bits are immediate
            default:     key = {opcode, funct3, funct7}; // R-type, SYSTEM, unknown
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/ctrl_table.sv
// Key-to-control-word lookup over the RV32I table, unmatched keys give an all-zero word
`default_nettype none

`include "rv_decode_config.svh"

module ctrl_table (
    input  rv_decode_pkg::inst_key_t  key,        // From the key former
    output rv_decode_pkg::ctrl_word_t table_ctrl  // Raw control word
);
    import rv_decode_pkg::*;

    localparam int unsigned ENTRY_W = `RV_KEY_W + `RV_CTRL_W;

    // {opcode, funct3, funct7, alu_op_op1_op2_pc_we_men_mwen_wb}
    localparam logic [ENTRY_W-1:0] LUT [`RV_NR_KEY] = '{
        {`OPC_OP,     3'b000, 7'b0000000, 17'b00000_10_11_000_1_0_0_10}, // ADD
        {`OPC_OP,     3'b000, 7'b0100000, 17'b00001_00_11_000_1_0_0_10}, // SUB
        {`OPC_OP,     3'b001, 7'b0000000, 17'b00111_00_11_000_1_0_0_10}, // SLL
        {`OPC_OP,     3'b010, 7'b0000000, 17'b00010_00_11_000_1_0_0_10}, // SLT
        {`OPC_OP,     3'b011, 7'b0000000, 17'b00011_00_11_000_1_0_0_10}, // SLTU
        {`OPC_OP,     3'b100, 7'b0000000, 17'b00100_00_11_000_1_0_0_10}, // XOR
        {`OPC_OP,     3'b101, 7'b0000000, 17'b01000_00_11_000_1_0_0_10}, // SRL
        {`OPC_OP,     3'b101, 7'b0100000, 17'b01001_00_11_000_1_0_0_10}, // SRA
        {`OPC_OP,     3'b110, 7'b0000000, 17'b00101_00_11_000_1_0_0_10}, // OR
        {`OPC_OP,     3'b111, 7'b0000000, 17'b00110_00_11_000_1_0_0_10}, // AND
        {`OPC_OP_IMM, 3'b000, 7'b0000000, 17'b00000_00_01_000_1_0_0_10}, // ADDI
        {`OPC_OP_IMM, 3'b010, 7'b0000000, 17'b00010_00_01_000_1_0_0_10}, // SLTI
        {`OPC_OP_IMM, 3'b011, 7'b0000000, 17'b00011_00_01_000_1_0_0_10}, // SLTIU
        {`OPC_OP_IMM, 3'b100, 7'b0000000, 17'b00100_00_01_000_1_0_0_10}, // XORI
        {`OPC_OP_IMM, 3'b110, 7'b0000000, 17'b00101_00_01_000_1_0_0_10}, // ORI
        {`OPC_OP_IMM, 3'b111, 7'b0000000, 17'b00110_00_01_000_1_0_0_10}, // ANDI
        {`OPC_OP_IMM, 3'b001, 7'b0000000, 17'b00111_00_01_000_1_0_0_10}, // SLLI
        {`OPC_OP_IMM, 3'b101, 7'b0000000, 17'b01000_00_01_000_1_0_0_10}, // SRLI
        {`OPC_OP_IMM, 3'b101, 7'b0100000, 17'b01001_00_01_000_1_0_0_10}, // SRAI
        {`OPC_LOAD,   3'b010, 7'b0000000, 17'b00000_00_01_000_1_1_0_11}, // LW
        {`OPC_LOAD,   3'b000, 7'b0000000, 17'b00000_00_01_000_1_1_0_11}, // LB
        {`OPC_LOAD,   3'b100, 7'b0000000, 17'b00000_00_01_000_1_1_0_11}, // LBU
        {`OPC_LOAD,   3'b001, 7'b0000000, 17'b00000_00_01_000_1_1_0_11}, // LH
        {`OPC_LOAD,   3'b101, 7'b0000000, 17'b00000_00_01_000_1_1_0_11}, // LHU
        {`OPC_BRANCH, 3'b000, 7'b0000000, 17'b00000_00_00_000_0_0_0_10}, // BEQ
        {`OPC_BRANCH, 3'b001, 7'b0000000, 17'b00000_00_00_000_0_0_0_10}, // BNE
        {`OPC_BRANCH, 3'b100, 7'b0000000, 17'b00000_00_00_000_0_0_0_10}, // BLT
        {`OPC_BRANCH, 3'b101, 7'b0000000, 17'b00000_00_00_000_0_0_0_10}, // BGE
        {`OPC_BRANCH, 3'b110, 7'b0000000, 17'b00000_00_00_000_0_0_0_10}, // BLTU
        {`OPC_BRANCH, 3'b111, 7'b0000000, 17'b00000_00_00_000_0_0_0_10}, // BGEU
        {`OPC_JAL,    3'b000, 7'b0000000, {9'b00000_00_00, `PC_SEL_JAL, 5'b1_0_0_01}},
        {`OPC_AUIPC,  3'b000, 7'b0000000, 17'b00000_01_00_000_1_0_0_10}, // AUIPC
        {`OPC_LUI,    3'b000, 7'b0000000, 17'b01010_01_00_000_1_0_0_10}, // LUI
        {`OPC_STORE,  3'b010, 7'b0000000, 17'b00000_00_10_000_0_1_1_00}, // SW
        {`OPC_STORE,  3'b000, 7'b0000000, 17'b00000_00_10_000_0_1_1_00}, // SB
        {`OPC_STORE,  3'b001, 7'b0000000, 17'b00000_00_10_000_0_1_1_00}, // SH
        {`OPC_JALR,   3'b000, 7'b0000000, {9'b00000_00_01, `PC_SEL_JALR, 5'b1_0_0_01}},
        {`OPC_SYSTEM, 3'b000, 7'b0000000, 17'b00000_00_00_000_0_0_0_00}  // EBREAK
    };

    // Keys are unique, so at most one entry hits
    always_comb begin
        table_ctrl = '0;                                      // No hit, all zero
        for (int i = 0; i < `RV_NR_KEY; i++) begin
            if (key == LUT[i][ENTRY_W-1 -: `RV_KEY_W]) begin
                table_ctrl = LUT[i][`RV_CTRL_W-1:0];          // Control half of entry
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/branch_resolver.sv
// Resolves the next-PC select for conditional branches from funct3 and the compare flags
`default_nettype none

`include "rv_decode_config.svh"

module branch_resolver (
    input  rv_decode_pkg::inst_t      inst,        // For opcode and funct3
    input  rv_decode_pkg::br_flags_t  br,          // Comparator results
    input  rv_decode_pkg::ctrl_word_t table_ctrl,  // Word from the table
    output rv_decode_pkg::ctrl_word_t ctrl         // Final control word
);
    import rv_decode_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    logic    taken;  // Branch condition holds

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];

    always_comb begin
        case (funct3)
            3'b000:  taken = br.eq;    // BEQ
            3'b001:  taken = ~br.eq;   // BNE
            3'b100:  taken = br.lt;    // BLT
            3'b101:  taken = ~br.lt;   // BGE
            3'b110:  taken = br.ltu;   // BLTU
            3'b111:  taken = ~br.ltu;  // BGEU
            default: taken = 1'b0;     // Reserved funct3, fall through
        endcase
    end

    always_comb begin
        ctrl = table_ctrl;                                    // Only pc_sel may change
        if (opcode == `OPC_BRANCH) begin
            ctrl.pc_sel = taken ? `PC_SEL_BRANCH : `PC_SEL_SEQ;
        end
    end

endmodule

`default_nettype wire

// File: hdl/mem_sys_decoder.sv
// Decodes the load/store access width code and flags the exact ebreak instruction word
`default_nettype none

`include "rv_decode_config.svh"

module mem_sys_decoder (
    input  rv_decode_pkg::inst_t       inst,        // Instruction word
    output rv_decode_pkg::mem_access_t mem_access,  // funct3 for legal loads/stores
    output logic                       is_ebreak    // Exact ebreak match
);
    import rv_decode_pkg::*;

    opcode_t opcode;
    funct3_t funct3;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];

    always_comb begin
        mem_access = '0;                                      // Not a memory op
        if (opcode == `OPC_LOAD) begin
            case (funct3)
                3'b000, 3'b001, 3'b010,                       // LB, LH, LW
                3'b100, 3'b101: mem_access = funct3;          // LBU, LHU
                default:        mem_access = '0;
            endcase
        end else if (opcode == `OPC_STORE) begin
            case (funct3)
                3'b000, 3'b001, 3'b010: mem_access = funct3;  // SB, SH, SW
                default:                mem_access = '0;
            endcase
        end
    end

    assign is_ebreak = (inst == `EBREAK_WORD);  // ECALL and others stay low

endmodule

`default_nettype wire

// File: hdl/rv_control_logic.sv
// Top of the RV32I control decoder, wiring key former, table, branch and memory decode
`default_nettype none

module rv_control_logic (
    input  rv_decode_pkg::inst_t       inst,        // Instruction word
    input  rv_decode_pkg::br_flags_t   br,          // Branch compare flags
    output rv_decode_pkg::ctrl_word_t  ctrl,        // Decoded control word
    output rv_decode_pkg::mem_access_t mem_access,  // Load/store width code
    output logic                       is_ebreak    // Ebreak detected
);
    import rv_decode_pkg::*;

    inst_key_t  key;         // Table lookup key
    ctrl_word_t table_ctrl;  // Before branch resolution

    inst_key_former u_key_former (
        .inst (inst),
        .key  (key)
    );

    ctrl_table u_ctrl_table (
        .key        (key),
        .table_ctrl (table_ctrl)
    );

    branch_resolver u_branch_resolver (
        .inst       (inst),
        .br         (br),
        .table_ctrl (table_ctrl),
        .ctrl       (ctrl)
    );

    mem_sys_decoder u_mem_sys_decoder (
        .inst       (inst),
        .mem_access (mem_access),
        .is_ebreak  (is_ebreak)
    );

endmodule

`default_nettype wire

// File: bench/rv_control_logic_properties.sv
// Consistency checks on the decoder outputs, bound into the decoder top by the testbench
`default_nettype none

module rv_control_logic_properties (
    input rv_decode_pkg::ctrl_word_t ctrl,       // Final control word
    input logic                      is_ebreak,  // Ebreak flag
    input logic                      clk         // Bench clock, sampling only
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned violations = 0;  // Failed assertion count

    // A store is always a memory access
    store_needs_mem_en: assert property (@(posedge clk) ctrl.mem_wen |-> ctrl.mem_en)
        else begin
            violations++;
            $error("Memory write enable is set without memory enable");
        end

    store_no_rf_write: assert property (@(posedge clk) ctrl.mem_wen |-> !ctrl.rf_we)
        else begin
            violations++;
            $error("Memory write enable and register write enable are both set");
        end

    // Ebreak decodes to a quiet control word
    ebreak_zero_word: assert property (@(posedge clk) is_ebreak |-> (ctrl == '0))
        else begin
            violations++;
            $error("Ebreak came with a nonzero control word");
        end

endmodule

`default_nettype wire

// File: bench/tb_rv_control_logic.sv
// Decoder testbench: runs the pattern file and random branch cases, prints a report
`default_nettype none

`include "rv_decode_config.svh"

module tb_rv_control_logic;
    timeunit 1ns;
    timeprecision 100ps;
    import rv_decode_pkg::*;

    localparam int RAND_CASES = 64;                          // Random branch tests
    localparam funct3_t BR_F3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};

    logic        clk = 1'b0;
    inst_t       inst;
    br_flags_t   br;
    ctrl_word_t  ctrl;
    mem_access_t mem_access;
    logic        is_ebreak;

    // Pattern file contents, one entry per test line
    string       pat_name [$];
    inst_t       pat_inst [$];
    br_flags_t   pat_br   [$];
    ctrl_word_t  pat_ctrl [$];
    mem_access_t pat_mem  [$];
    logic        pat_eb   [$];

    int test_errs    = 0;     // Mismatches in the current test
    int tests_run    = 0;
    int tests_failed = 0;
    int load_errors  = 0;     // Missing file or bad lines
    int cycle_count  = 0;
    int cycle_limit  = 1000;  // Set from the test count after loading

    always #4 clk = ~clk;     // 8 ns period

    rv_control_logic UUT (
        .inst       (inst),
        .br         (br),
        .ctrl       (ctrl),
        .mem_access (mem_access),
        .is_ebreak  (is_ebreak)
    );

    bind rv_control_logic rv_control_logic_properties u_props (
        .clk       (tb_rv_control_logic.clk),
        .ctrl      (ctrl),
        .is_ebreak (is_ebreak)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not end within %0d cycles", cycle_limit);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;             // Numerical Recipes constants
    endfunction

    // Branch rule: funct3[2:1] picks the flag, funct3[0] inverts it
    function automatic pc_sel_t expected_branch_pc(input funct3_t f3, input br_flags_t fl);
        logic cond;
        if (f3[2] == 1'b0) cond = fl.eq;
        else if (f3[1] == 1'b0) cond = fl.lt;
        else cond = fl.ltu;
        return (cond ^ f3[0]) ? `PC_SEL_BRANCH : `PC_SEL_SEQ;
    endfunction

    task automatic load_patterns();
        int          fd;
        int          n;
        string       line;
        string       f_name;
        logic [31:0] f_inst, f_br, f_alu, f_op1, f_op2, f_pc;
        logic [31:0] f_we, f_men, f_mwen, f_wb, f_mem, f_eb;
        ctrl_word_t  c;
        fd = $fopen("bench/decode_patterns.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the pattern file bench/decode_patterns.txt");
            load_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.getc(0) == "#") continue;  // Comment or blank
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h", f_name, f_inst,
                            f_br, f_alu, f_op1, f_op2, f_pc, f_we, f_men, f_mwen, f_wb,
                            f_mem, f_eb);
                if (n != 13) begin
                    $display("Malformed pattern line: %s", line);
                    load_errors++;
                end else begin
                    c.alu_op  = f_alu[4:0];
                    c.op1_sel = f_op1[1:0];
                    c.op2_sel = f_op2[1:0];
                    c.pc_sel  = f_pc[2:0];
                    c.rf_we   = f_we[0];
                    c.mem_en  = f_men[0];
                    c.mem_wen = f_mwen[0];
                    c.wb_sel  = f_wb[1:0];
                    pat_name.push_back(f_name);
                    pat_inst.push_back(f_inst);
                    pat_br.push_back(br_flags_t'(f_br[2:0]));  // {eq, lt, ltu}
                    pat_ctrl.push_back(c);
                    pat_mem.push_back(f_mem[2:0]);
                    pat_eb.push_back(f_eb[0]);
                end
            end
            $fclose(fd);
            if (pat_name.size() == 0) begin
                $display("The pattern file holds no tests");
                load_errors++;
            end
        end
    endtask

    task automatic check_ctrl(input string name, input ctrl_word_t exp, input ctrl_word_t act);
        if (act !== exp) begin
            $display("[FAIL] %s ctrl expected %h actual %h", name, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_mem_access(input string name, input mem_access_t exp,
                                    input mem_access_t act);
        if (act !== exp) begin
            $display("[FAIL] %s mem_access expected %h actual %h", name, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_ebreak(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s is_ebreak expected %b actual %b", name, exp, act);
            test_errs++;
        end
    endtask

    // Drive on the falling edge, compare on the next rising edge
    task automatic apply_and_check(input string name, input inst_t t_inst, input br_flags_t t_br,
                                   input ctrl_word_t e_ctrl, input mem_access_t e_mem,
                                   input logic e_eb);
        @(negedge clk);
        inst = t_inst;
        br   = t_br;
        @(posedge clk);
        test_errs = 0;
        check_ctrl(name, e_ctrl, ctrl);
        check_mem_access(name, e_mem, mem_access);
        check_ebreak(name, e_eb, is_ebreak);
        tests_run++;
        if (test_errs == 0) begin
            $display("[PASS] %s", name);
        end else begin
            tests_failed++;
            $display("Test %s finished with %0d mismatches", name, test_errs);
        end
    endtask

    initial begin
        logic [31:0] seed;
        funct3_t     f3;
        br_flags_t   rb;
        inst_t       ri;
        ctrl_word_t  ec;
        inst = '0;
        br   = '0;
        load_patterns();
        cycle_limit = 2 * (pat_name.size() + RAND_CASES) + 20;
        for (int i = 0; i < pat_name.size(); i++) begin
            apply_and_check(pat_name[i], pat_inst[i], pat_br[i], pat_ctrl[i], pat_mem[i],
                            pat_eb[i]);
        end
        seed = 32'h8914;
        for (int n = 0; n < RAND_CASES; n++) begin
            seed = lcg_next(seed);
            f3   = BR_F3[int'(seed[18:16]) % 6];              // Valid branch funct3 only
            rb   = br_flags_t'(seed[22:20]);
            ri   = {seed[31:25], 5'd3, 5'd2, f3, seed[12:8], `OPC_BRANCH};  // Random offset
            ec        = '0;
            ec.wb_sel = 2'd2;                                 // Branch table entries
            ec.pc_sel = expected_branch_pc(f3, rb);
            apply_and_check($sformatf("rand_branch_%0d", n), ri, rb, ec, '0, 1'b0);
        end
        @(negedge clk);                                       // Let the last assertions settle
        $display("Tests %0d run, %0d passed, %0d failed, %0d load errors, %0d assertion failures",
                 tests_run, tests_run - tests_failed, tests_failed, load_errors,
                 UUT.u_props.violations);
        if (tests_failed == 0 && load_errors == 0 && UUT.u_props.violations == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/decode_patterns.txt
# name inst br{eq,lt,ltu} alu_op op1_sel op2_sel pc_sel rf_we mem_en mem_wen wb_sel mem_access ebreak
# All numeric columns are hex, one test per line
ADD       003100B3 0 00 2 3 0 1 0 0 2 0 0
SUB       403100B3 0 01 0 3 0 1 0 0 2 0 0
SLL       003110B3 0 07 0 3 0 1 0 0 2 0 0
SLT       003120B3 0 02 0 3 0 1 0 0 2 0 0
SLTU      003130B3 0 03 0 3 0 1 0 0 2 0 0
XOR       003140B3 0 04 0 3 0 1 0 0 2 0 0
SRL       003150B3 0 08 0 3 0 1 0 0 2 0 0
SRA       403150B3 0 09 0 3 0 1 0 0 2 0 0
OR        003160B3 0 05 0 3 0 1 0 0 2 0 0
AND       003170B3 7 06 0 3 0 1 0 0 2 0 0
ADDI      00510093 0 00 0 1 0 1 0 0 2 0 0
ADDI_NEG  FFF10093 0 00 0 1 0 1 0 0 2 0 0
XORI      FFF14093 0 04 0 1 0 1 0 0 2 0 0
SLTIU     00513093 0 03 0 1 0 1 0 0 2 0 0
SLLI      00311093 0 07 0 1 0 1 0 0 2 0 0
SRLI      00315093 0 08 0 1 0 1 0 0 2 0 0
SRAI      40315093 0 09 0 1 0 1 0 0 2 0 0
SRAI_BAD  02315093 0 00 0 0 0 0 0 0 0 0 0
LW        00412083 0 00 0 1 0 1 1 0 3 2 0
LB        00410083 0 00 0 1 0 1 1 0 3 0 0
LBU       00414083 0 00 0 1 0 1 1 0 3 4 0
LH        00411083 0 00 0 1 0 1 1 0 3 1 0
LHU       00415083 0 00 0 1 0 1 1 0 3 5 0
LD_ILL    00413083 0 00 0 0 0 0 0 0 0 0 0
SW        00312423 0 00 0 2 0 0 1 1 0 2 0
SB        00310423 0 00 0 2 0 0 1 1 0 0 0
SH        00311423 0 00 0 2 0 0 1 1 0 1 0
JAL       008000EF 0 00 0 0 3 1 0 0 1 0 0
JALR      000100E7 0 00 0 1 1 1 0 0 1 0 0
JALR_F3   000110E7 0 00 0 0 0 0 0 0 0 0 0
LUI       123450B7 0 0A 1 0 0 1 0 0 2 0 0
AUIPC     12345097 0 00 1 0 0 1 0 0 2 0 0
BEQ_TAKEN 00310463 4 00 0 0 2 0 0 0 2 0 0
BNE_NOT   00311463 4 00 0 0 0 0 0 0 2 0 0
EBREAK    00100073 0 00 0 0 0 0 0 0 0 0 1
ECALL     00000073 0 00 0 0 0 0 0 0 0 0 0
ILLEGAL   0000007F 0 00 0 0 0 0 0 0 0 0 0

// File: sources.f
+incdir+hdl
hdl/rv_decode_pkg.sv
hdl/inst_key_former.sv
hdl/ctrl_table.sv
hdl/branch_resolver.sv
hdl/mem_sys_decoder.sv
hdl/rv_control_logic.sv
bench/rv_control_logic_properties.sv
bench/tb_rv_control_logic.sv

// File: run.sh
#!/bin/sh
# Builds the decoder testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_rv_control_logic \
    -f sources.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_rv_control_logic +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Regression passed" "$LOG"; then
    exit 0
fi
exit 1
